// File: logic/link_pkg.sv
package link_pkg;

    // Link state from the DLCM state machine
    typedef enum logic [1:0] {
        dlcm_inactive = 2'd0,
        dlcm_init1    = 2'd1,
        dlcm_init2    = 2'd2,
        dlcm_active   = 2'd3
    } dlcm_state_e;

    typedef enum logic [1:0] {
        fc_p   = 2'd0,
        fc_np  = 2'd1,
        fc_cpl = 2'd2
    } fc_class_e;

    typedef enum logic [1:0] {
        kind_init_fc1  = 2'd0,
        kind_init_fc2  = 2'd1,
        kind_update_fc = 2'd2,
        kind_acknak    = 2'd3
    } dllp_kind_e;

    typedef struct packed {
        dllp_kind_e kind;
        fc_class_e  fc_class;   // Don't care for Ack/Nak
    } dllp_req_t;

    typedef struct packed {
        logic [7:0]  hdr;
        logic [11:0] data;
    } fc_credit_t;

endpackage

// File: logic/dllp_pkg.sv
package dllp_pkg;

    typedef struct packed {
        logic [1:0]  hdr_scale;
        logic [7:0]  hdr_fc;
        logic [1:0]  data_scale;
        logic [11:0] data_fc;
    } fc_payload_t;

    typedef struct packed {
        logic [11:0] reserved;
        logic [11:0] seq_num;
    } acknak_payload_t;

    // Decoded by the type byte
    typedef union packed {
        fc_payload_t     fc;
        acknak_payload_t acknak;
    } dllp_payload_u;

    typedef struct packed {
        logic [7:0]    dllp_type;
        dllp_payload_u payload;
    } dllp_body_t;

    typedef struct packed {
        dllp_body_t  body;
        logic [15:0] crc;
    } dllp_word_t;

    localparam logic [7:0] type_init_fc1_p   = 8'h40;
    localparam logic [7:0] type_init_fc1_np  = 8'h50;
    localparam logic [7:0] type_init_fc1_cpl = 8'h60;
    localparam logic [7:0] type_init_fc2_p   = 8'hC0;
    localparam logic [7:0] type_init_fc2_np  = 8'hD0;
    localparam logic [7:0] type_init_fc2_cpl = 8'hE0;
    localparam logic [7:0] type_update_p     = 8'h80;
    localparam logic [7:0] type_update_np    = 8'h90;
    localparam logic [7:0] type_update_cpl   = 8'hA0;
    localparam logic [7:0] type_ack          = 8'h00;
    localparam logic [7:0] type_nak          = 8'h10;

    localparam logic [15:0] crc_poly  = 16'h100B;
    localparam logic [15:0] crc_seed  = 16'hFFFF;
    localparam logic [15:0] sdp_token = 16'hACF0;   // SDP framing ahead of the DLLP

endpackage

// File: logic/dllp_scheduler.sv
`timescale 1ns/1ns

module dllp_scheduler
    import link_pkg::*;
#(
    parameter int resend_period = 1024
)(
    input  logic        sclk,
    input  logic        rst_n_i,
    input  dlcm_state_e dlcm_state_i,
    output dllp_req_t   req_o,
    output logic        req_valid_o,
    input  logic        req_ready_i,
    output logic        flush_o,
    output logic        init1_done_o,
    output logic        init2_done_o
);

    localparam int cnt_w = $clog2(resend_period + 1);

    typedef enum logic [1:0] {
        s_idle,
        s_issue,
        s_gap
    } sched_phase_e;

    sched_phase_e     phase_q;
    dlcm_state_e      state_q;
    logic             flush_q;
    logic [1:0]       idx_q;        // Slot within the round
    logic [cnt_w-1:0] gap_cnt_q;
    logic             init1_done_q;
    logic             init2_done_q;

    logic state_change;
    logic req_fire;
    logic last_req;

    assign state_change = (dlcm_state_i != state_q);
    assign req_fire     = req_valid_o && req_ready_i;
    // Active rounds carry the extra Ack/Nak slot
    assign last_req     = (state_q == dlcm_active) ? (idx_q == 2'd3) : (idx_q == 2'd2);

    always_comb begin
        case (state_q)
            dlcm_init1: req_o.kind = kind_init_fc1;
            dlcm_init2: req_o.kind = kind_init_fc2;
            default:    req_o.kind = (idx_q == 2'd3) ? kind_acknak : kind_update_fc;
        endcase
        case (idx_q)
            2'd1:    req_o.fc_class = fc_np;
            2'd2:    req_o.fc_class = fc_cpl;
            default: req_o.fc_class = fc_p;
        endcase
    end

    assign req_valid_o  = (phase_q == s_issue);
    assign flush_o      = flush_q;
    assign init1_done_o = init1_done_q;
    assign init2_done_o = init2_done_q;

    always_ff @(posedge sclk) begin
        if (!rst_n_i) begin
            state_q      <= dlcm_inactive;
            flush_q      <= 1'b0;
            phase_q      <= s_idle;
            idx_q        <= 2'd0;
            gap_cnt_q    <= '0;
            init1_done_q <= 1'b0;
            init2_done_q <= 1'b0;
        end else begin
            state_q <= dlcm_state_i;
            flush_q <= state_change;
            if (state_change) begin
                // Restart on any link state change
                phase_q      <= s_idle;
                idx_q        <= 2'd0;
                gap_cnt_q    <= '0;
                init1_done_q <= 1'b0;
                init2_done_q <= 1'b0;
            end else begin
                case (phase_q)
                    s_idle: begin
                        if (state_q != dlcm_inactive) begin
                            phase_q <= s_issue;
                        end
                    end
                    s_issue: begin
                        if (req_fire && last_req) begin
                            phase_q   <= s_gap;
                            idx_q     <= 2'd0;
                            gap_cnt_q <= '0;
                            if (state_q == dlcm_init1) begin
                                init1_done_q <= 1'b1;
                            end
                            if (state_q == dlcm_init2) begin
                                init2_done_q <= 1'b1;
                            end
                        end else if (req_fire) begin
                            idx_q <= idx_q + 2'd1;
                        end
                    end
                    s_gap: begin
                        if (gap_cnt_q == cnt_w'(resend_period - 1)) begin
                            phase_q <= s_issue;   // Resend the whole round
                        end else begin
                            gap_cnt_q <= gap_cnt_q + 1'b1;
                        end
                    end
                    default: phase_q <= s_idle;
                endcase
            end
        end
    end

endmodule

// File: logic/dllp_assembler.sv
`timescale 1ns/1ns

module dllp_assembler
    import link_pkg::*;
    import dllp_pkg::*;
#(
    parameter int credit_limit_p_hdr    = 16,
    parameter int credit_limit_p_data   = 16,
    parameter int credit_limit_np_hdr   = 16,
    parameter int credit_limit_cpl_hdr  = 16,
    parameter int credit_limit_cpl_data = 16
)(
    input  logic        sclk,
    input  logic        rst_n_i,
    input  logic        flush_i,
    input  dllp_req_t   req_i,
    input  logic        req_valid_i,
    output logic        req_ready_o,
    input  fc_credit_t  cc_p_i,
    input  logic [7:0]  cc_np_hdr_i,
    input  fc_credit_t  cc_cpl_i,
    input  logic        nak_scheduled_i,
    input  logic [11:0] next_rcv_seq_i,
    output dllp_body_t  body_o,
    output logic        body_valid_o,
    input  logic        body_ready_i
);

    dllp_body_t body_d;
    dllp_body_t body_q;
    logic       body_valid_q;
    logic       req_fire;
    fc_credit_t credit;
    logic [7:0] fc_type;

    assign req_ready_o = !body_valid_q || body_ready_i;
    assign req_fire    = req_valid_i && req_ready_o;

    always_comb begin
        credit = '0;
        if (req_i.kind == kind_update_fc) begin
            case (req_i.fc_class)
                fc_p:    credit = cc_p_i;
                fc_np:   credit.hdr = cc_np_hdr_i;
                default: credit = cc_cpl_i;
            endcase
        end else begin
            case (req_i.fc_class)
                fc_p: begin
                    credit.hdr  = 8'(credit_limit_p_hdr);
                    credit.data = 12'(credit_limit_p_data);
                end
                fc_np:   credit.hdr = 8'(credit_limit_np_hdr);   // NP has no data credits
                default: begin
                    credit.hdr  = 8'(credit_limit_cpl_hdr);
                    credit.data = 12'(credit_limit_cpl_data);
                end
            endcase
        end
    end

    always_comb begin
        case ({req_i.kind, req_i.fc_class})
            {kind_init_fc1, fc_np}:   fc_type = type_init_fc1_np;
            {kind_init_fc1, fc_cpl}:  fc_type = type_init_fc1_cpl;
            {kind_init_fc2, fc_p}:    fc_type = type_init_fc2_p;
            {kind_init_fc2, fc_np}:   fc_type = type_init_fc2_np;
            {kind_init_fc2, fc_cpl}:  fc_type = type_init_fc2_cpl;
            {kind_update_fc, fc_p}:   fc_type = type_update_p;
            {kind_update_fc, fc_np}:  fc_type = type_update_np;
            {kind_update_fc, fc_cpl}: fc_type = type_update_cpl;
            default:                  fc_type = type_init_fc1_p;
        endcase
    end

    // Scale and reserved fields stay zero
    always_comb begin
        body_d = '0;
        if (req_i.kind == kind_acknak) begin
            body_d.dllp_type              = nak_scheduled_i ? type_nak : type_ack;
            body_d.payload.acknak.seq_num = next_rcv_seq_i;
        end else begin
            body_d.dllp_type          = fc_type;
            body_d.payload.fc.hdr_fc  = credit.hdr;
            body_d.payload.fc.data_fc = credit.data;
        end
    end

    always_ff @(posedge sclk) begin
        if (!rst_n_i || flush_i) begin
            body_valid_q <= 1'b0;
        end else if (req_fire) begin
            body_valid_q <= 1'b1;
        end else if (body_ready_i) begin
            body_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge sclk) begin
        if (req_fire) begin
            body_q <= body_d;   // Inputs sampled on accept
        end
    end

    assign body_o       = body_q;
    assign body_valid_o = body_valid_q;

endmodule

// File: logic/dllp_crc_stage.sv
`timescale 1ns/1ns

module dllp_crc_stage
    import dllp_pkg::*;
(
    input  logic       sclk,
    input  logic       rst_n_i,
    input  logic       flush_i,
    input  dllp_body_t body_i,
    input  logic       body_valid_i,
    output logic       body_ready_o,
    output dllp_word_t word_o,
    output logic       word_valid_o,
    input  logic       word_ready_i
);

    logic [15:0] crc_reg;
    dllp_word_t  word_q;
    logic        word_valid_q;
    logic        body_fire;

    assign body_ready_o = !word_valid_q || word_ready_i;
    assign body_fire    = body_valid_i && body_ready_o;

    // Bit-serial CRC-16 unrolled over the 32 body bits, MSB first
    always_comb begin
        crc_reg = crc_seed;
        for (int i = 31; i >= 0; i--) begin
            if (crc_reg[15] ^ body_i[i]) begin
                crc_reg = {crc_reg[14:0], 1'b0} ^ crc_poly;
            end else begin
                crc_reg = {crc_reg[14:0], 1'b0};
            end
        end
    end

    always_ff @(posedge sclk) begin
        if (!rst_n_i || flush_i) begin
            word_valid_q <= 1'b0;
        end else if (body_fire) begin
            word_valid_q <= 1'b1;
        end else if (word_ready_i) begin
            word_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge sclk) begin
        if (body_fire) begin
            word_q.body <= body_i;
            word_q.crc  <= ~crc_reg;
        end
    end

    assign word_o       = word_q;
    assign word_valid_o = word_valid_q;

endmodule

// File: logic/dllp_framer.sv
`timescale 1ns/1ns

module dllp_framer
    import dllp_pkg::*;
#(
    parameter int pipe_data_width = 256   // At least 64
)(
    input  logic                       sclk,
    input  logic                       rst_n_i,
    input  logic                       flush_i,
    input  dllp_word_t                 word_i,
    input  logic                       word_valid_i,
    output logic                       word_ready_o,
    output logic [pipe_data_width-1:0] dllp_data_o,
    output logic                       dllp_valid_o,
    input  logic                       arb_ready_i
);

    logic [pipe_data_width-1:0] data_d;
    logic [pipe_data_width-1:0] data_q;
    logic                       valid_q;
    logic                       word_fire;

    assign word_ready_o = !valid_q || arb_ready_i;
    assign word_fire    = word_valid_i && word_ready_o;

    always_comb begin
        data_d        = '0;
        data_d[15:0]  = sdp_token;
        data_d[63:16] = word_i;
    end

    always_ff @(posedge sclk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (word_fire) begin
            valid_q <= 1'b1;
        end else if (arb_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge sclk) begin
        if (word_fire) begin
            data_q <= data_d;   // Held until the arbiter takes it
        end
    end

    assign dllp_data_o  = data_q;
    assign dllp_valid_o = valid_q;

endmodule

// File: logic/dllp_generator.sv
`timescale 1ns/1ns

module dllp_generator
    import link_pkg::*;
    import dllp_pkg::*;
#(
    parameter int resend_period         = 1024,
    parameter int credit_limit_p_hdr    = 16,
    parameter int credit_limit_p_data   = 16,
    parameter int credit_limit_np_hdr   = 16,
    parameter int credit_limit_cpl_hdr  = 16,
    parameter int credit_limit_cpl_data = 16,
    parameter int pipe_data_width       = 256
)(
    input  logic                       sclk,
    input  logic                       rst_n_i,
    input  dlcm_state_e                dlcm_state_i,
    input  fc_credit_t                 cc_p_i,
    input  logic [7:0]                 cc_np_hdr_i,
    input  fc_credit_t                 cc_cpl_i,
    input  logic                       nak_scheduled_i,
    input  logic [11:0]                next_rcv_seq_i,
    output logic [pipe_data_width-1:0] dllp_data_o,
    output logic                       dllp_valid_o,
    input  logic                       arb_ready_i,
    output logic                       init1_done_o,
    output logic                       init2_done_o
);

    dllp_req_t  req;
    logic       req_valid;
    logic       req_ready;
    logic       flush;
    dllp_body_t body;
    logic       body_valid;
    logic       body_ready;
    dllp_word_t word;
    logic       word_valid;
    logic       word_ready;

    dllp_scheduler #(
        .resend_period (resend_period)
    ) i_scheduler (
        .sclk         (sclk),
        .rst_n_i      (rst_n_i),
        .dlcm_state_i (dlcm_state_i),
        .req_o        (req),
        .req_valid_o  (req_valid),
        .req_ready_i  (req_ready),
        .flush_o      (flush),
        .init1_done_o (init1_done_o),
        .init2_done_o (init2_done_o)
    );

    dllp_assembler #(
        .credit_limit_p_hdr    (credit_limit_p_hdr),
        .credit_limit_p_data   (credit_limit_p_data),
        .credit_limit_np_hdr   (credit_limit_np_hdr),
        .credit_limit_cpl_hdr  (credit_limit_cpl_hdr),
        .credit_limit_cpl_data (credit_limit_cpl_data)
    ) i_assembler (
        .sclk            (sclk),
        .rst_n_i         (rst_n_i),
        .flush_i         (flush),
        .req_i           (req),
        .req_valid_i     (req_valid),
        .req_ready_o     (req_ready),
        .cc_p_i          (cc_p_i),
        .cc_np_hdr_i     (cc_np_hdr_i),
        .cc_cpl_i        (cc_cpl_i),
        .nak_scheduled_i (nak_scheduled_i),
        .next_rcv_seq_i  (next_rcv_seq_i),
        .body_o          (body),
        .body_valid_o    (body_valid),
        .body_ready_i    (body_ready)
    );

    dllp_crc_stage i_crc_stage (
        .sclk         (sclk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush),
        .body_i       (body),
        .body_valid_i (body_valid),
        .body_ready_o (body_ready),
        .word_o       (word),
        .word_valid_o (word_valid),
        .word_ready_i (word_ready)
    );

    dllp_framer #(
        .pipe_data_width (pipe_data_width)
    ) i_framer (
        .sclk         (sclk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush),
        .word_i       (word),
        .word_valid_i (word_valid),
        .word_ready_o (word_ready),
        .dllp_data_o  (dllp_data_o),
        .dllp_valid_o (dllp_valid_o),
        .arb_ready_i  (arb_ready_i)
    );

endmodule

// File: dv/dllp_generator_properties.sv
`timescale 1ns/1ns

module dllp_generator_properties
    import link_pkg::*;
#(
    parameter int pipe_data_width = 256
)(
    input logic                       sclk,
    input logic                       rst_n_i,
    input dlcm_state_e                dlcm_state_i,
    input logic [pipe_data_width-1:0] dllp_data_i,
    input logic                       dllp_valid_i,
    input logic                       arb_ready_i,
    input logic                       init1_done_i,
    input logic                       init2_done_i
);

    dlcm_state_e state_q;
    logic        flush_q;
    int          fail_count = 0;

    // Shadow copy of the scheduler's state register and flush pulse
    always_ff @(posedge sclk) begin
        if (!rst_n_i) begin
            state_q <= dlcm_inactive;
            flush_q <= 1'b0;
        end else begin
            state_q <= dlcm_state_i;
            flush_q <= (dlcm_state_i != state_q);
        end
    end

    a_beat_held: assert property (@(posedge sclk) disable iff (!rst_n_i)
        dllp_valid_i && !arb_ready_i && !flush_q |=> dllp_valid_i && $stable(dllp_data_i))
        else begin
            fail_count++;
            $error("output beat changed or dropped during an arbiter stall");
        end

    a_init1_flag: assert property (@(posedge sclk) disable iff (!rst_n_i)
        state_q != dlcm_init1 |-> !init1_done_i)
        else begin
            fail_count++;
            $error("init1 done flag high outside the init1 state");
        end

    a_init2_flag: assert property (@(posedge sclk) disable iff (!rst_n_i)
        state_q != dlcm_init2 |-> !init2_done_i)
        else begin
            fail_count++;
            $error("init2 done flag high outside the init2 state");
        end

    // Only the low 64 bits carry the token and the DLLP
    a_upper_zero: assert property (@(posedge sclk) disable iff (!rst_n_i)
        dllp_valid_i |-> dllp_data_i[pipe_data_width-1:64] == '0)
        else begin
            fail_count++;
            $error("nonzero bits above bit 63 of the output beat");
        end

endmodule

bind dllp_generator dllp_generator_properties #(
    .pipe_data_width (pipe_data_width)
) i_properties (
    .sclk         (sclk),
    .rst_n_i      (rst_n_i),
    .dlcm_state_i (dlcm_state_i),
    .dllp_data_i  (dllp_data_o),
    .dllp_valid_i (dllp_valid_o),
    .arb_ready_i  (arb_ready_i),
    .init1_done_i (init1_done_o),
    .init2_done_i (init2_done_o)
);

// File: dv/dllp_generator_tb.sv
`timescale 1ns/1ns

module dllp_generator_tb
    import link_pkg::*;
();

    localparam int          pipe_w       = 256;
    localparam int          num_rows     = 9;
    localparam int          row_timeout  = 400;
    localparam int          quiet_cycles = 40;
    localparam logic [7:0]  lim_p_hdr    = 8'h21;
    localparam logic [11:0] lim_p_data   = 12'h345;
    localparam logic [7:0]  lim_np_hdr   = 8'h32;
    localparam logic [7:0]  lim_cpl_hdr  = 8'h43;
    localparam logic [11:0] lim_cpl_data = 12'h567;

    typedef struct packed {
        dlcm_state_e state;
        fc_credit_t  cc_p;
        logic [7:0]  cc_np_hdr;
        fc_credit_t  cc_cpl;
        logic        nak;
        logic [11:0] seq;
        logic [3:0]  beats;     // 0 means watch for silence
        logic        stall;
    } row_t;

    logic              sclk;
    logic              rst_n_i;
    dlcm_state_e       dlcm_state_i;
    fc_credit_t        cc_p_i;
    logic [7:0]        cc_np_hdr_i;
    fc_credit_t        cc_cpl_i;
    logic              nak_scheduled_i;
    logic [11:0]       next_rcv_seq_i;
    logic              arb_ready_i;
    logic [pipe_w-1:0] dllp_data_o;
    logic              dllp_valid_o;
    logic              init1_done_o;
    logic              init2_done_o;

    row_t        rows [num_rows];
    logic [15:0] lfsr;
    int          checks;
    int          mismatches;
    int          failures;

    dllp_generator #(
        .resend_period         (20),
        .credit_limit_p_hdr    (lim_p_hdr),
        .credit_limit_p_data   (lim_p_data),
        .credit_limit_np_hdr   (lim_np_hdr),
        .credit_limit_cpl_hdr  (lim_cpl_hdr),
        .credit_limit_cpl_data (lim_cpl_data),
        .pipe_data_width       (pipe_w)
    ) i_dut (
        .sclk            (sclk),
        .rst_n_i         (rst_n_i),
        .dlcm_state_i    (dlcm_state_i),
        .cc_p_i          (cc_p_i),
        .cc_np_hdr_i     (cc_np_hdr_i),
        .cc_cpl_i        (cc_cpl_i),
        .nak_scheduled_i (nak_scheduled_i),
        .next_rcv_seq_i  (next_rcv_seq_i),
        .dllp_data_o     (dllp_data_o),
        .dllp_valid_o    (dllp_valid_o),
        .arb_ready_i     (arb_ready_i),
        .init1_done_o    (init1_done_o),
        .init2_done_o    (init2_done_o)
    );

    initial begin
        sclk = 1'b0;
        forever #50 sclk = ~sclk;
    end

    // Taps x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [15:0] crc16(logic [31:0] body);
        logic [15:0] r;
        logic        fb;
        r = 16'hFFFF;
        for (int i = 31; i >= 0; i--) begin
            fb = r[15] ^ body[i];
            r  = r << 1;
            if (fb) begin
                r = r ^ 16'h100B;
            end
        end
        return ~r;
    endfunction

    function automatic row_t make_row(dlcm_state_e st, logic [19:0] cp, logic [7:0] cnp,
                                      logic [19:0] ccpl, logic nak, logic [11:0] seq,
                                      int beats, logic stall);
        row_t r;
        r.state     = st;
        r.cc_p      = cp;
        r.cc_np_hdr = cnp;
        r.cc_cpl    = ccpl;
        r.nak       = nak;
        r.seq       = seq;
        r.beats     = 4'(beats);
        r.stall     = stall;
        return r;
    endfunction

    // Beat idx of the repeating round in state r.state
    function automatic logic [pipe_w-1:0] expected_beat(row_t r, int idx);
        logic [7:0]  dtype;
        logic [7:0]  hdr;
        logic [11:0] data;
        logic [23:0] payload;
        logic [31:0] body;
        int          slot;
        slot = (r.state == dlcm_active) ? idx % 4 : idx % 3;
        case (r.state)
            dlcm_init1: dtype = 8'h40;
            dlcm_init2: dtype = 8'hC0;
            default:    dtype = 8'h80;
        endcase
        dtype = dtype + 8'(slot * 16);   // P, NP, CPL step by 0x10
        if (r.state == dlcm_active) begin
            hdr  = (slot == 0) ? r.cc_p.hdr : (slot == 1) ? r.cc_np_hdr : r.cc_cpl.hdr;
            data = (slot == 0) ? r.cc_p.data : (slot == 2) ? r.cc_cpl.data : 12'h000;
        end else begin
            hdr  = (slot == 0) ? lim_p_hdr : (slot == 1) ? lim_np_hdr : lim_cpl_hdr;
            data = (slot == 0) ? lim_p_data : (slot == 2) ? lim_cpl_data : 12'h000;
        end
        payload = {2'b00, hdr, 2'b00, data};
        if (slot == 3) begin
            dtype   = r.nak ? 8'h10 : 8'h00;
            payload = {12'h000, r.seq};
        end
        body = {dtype, payload};
        return {192'b0, body, crc16(body), 16'hACF0};
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    // Entered and left on a falling edge
    task automatic run_row(input row_t r);
        int                got;
        int                cycles;
        logic              ready;
        logic [pipe_w-1:0] exp_beat;
        dlcm_state_i    = r.state;
        cc_p_i          = r.cc_p;
        cc_np_hdr_i     = r.cc_np_hdr;
        cc_cpl_i        = r.cc_cpl;
        nak_scheduled_i = r.nak;
        next_rcv_seq_i  = r.seq;
        arb_ready_i     = 1'b1;
        repeat (2) @(negedge sclk);   // Beats of the old state drain or get flushed
        check_bit("init1_done_o", init1_done_o, 1'b0);
        check_bit("init2_done_o", init2_done_o, 1'b0);
        if (r.beats == 0) begin
            repeat (quiet_cycles) begin
                @(negedge sclk);
                check_bit("dllp_valid_o", dllp_valid_o, 1'b0);
                check_bit("init1_done_o", init1_done_o, 1'b0);
                check_bit("init2_done_o", init2_done_o, 1'b0);
            end
        end
        got    = 0;
        cycles = 0;
        while (got < r.beats && cycles < row_timeout) begin
            @(negedge sclk);
            cycles++;
            ready = 1'b1;
            if (r.stall) begin
                lfsr  = lfsr_next(lfsr);
                ready = lfsr[0];
            end
            arb_ready_i = ready;
            if (r.state != dlcm_init1) check_bit("init1_done_o", init1_done_o, 1'b0);
            if (r.state != dlcm_init2) check_bit("init2_done_o", init2_done_o, 1'b0);
            if (dllp_valid_o && ready) begin
                exp_beat = expected_beat(r, got);
                checks++;
                assert (dllp_data_o === exp_beat) else begin
                    mismatches++;
                    $display("mismatch dllp_data_o beat %0d: got %h expected %h",
                             got, dllp_data_o, exp_beat);
                end
                if (r.state == dlcm_init1 && got % 3 == 2) begin
                    check_bit("init1_done_o", init1_done_o, 1'b1);
                end
                if (r.state == dlcm_init2 && got % 3 == 2) begin
                    check_bit("init2_done_o", init2_done_o, 1'b1);
                end
                got++;
            end
        end
        checks++;
        assert (got >= r.beats) else begin
            failures++;
            $display("timeout in state %0d: only %0d of %0d beats arrived",
                     r.state, got, r.beats);
        end
    endtask

    initial begin
        lfsr            = 16'd54648;
        checks          = 0;
        mismatches      = 0;
        failures        = 0;
        rst_n_i         = 1'b0;
        dlcm_state_i    = dlcm_inactive;
        cc_p_i          = '0;
        cc_np_hdr_i     = '0;
        cc_cpl_i        = '0;
        nak_scheduled_i = 1'b0;
        next_rcv_seq_i  = '0;
        arb_ready_i     = 1'b0;
        rows[0] = make_row(dlcm_inactive, 20'h0, 8'h00, 20'h0, 1'b0, 12'h000, 0, 1'b0);
        rows[1] = make_row(dlcm_init1, 20'h0, 8'h00, 20'h0, 1'b0, 12'h000, 6, 1'b0);
        rows[2] = make_row(dlcm_init2, 20'h0, 8'h00, 20'h0, 1'b0, 12'h000, 6, 1'b0);
        rows[3] = make_row(dlcm_active, 20'h110AB, 8'h07, 20'h3C1F2, 1'b0, 12'h123, 8, 1'b0);
        rows[4] = make_row(dlcm_inactive, 20'h0, 8'h00, 20'h0, 1'b0, 12'h000, 0, 1'b0);
        rows[5] = make_row(dlcm_active, 20'h5A777, 8'h19, 20'hE2001, 1'b1, 12'hABC, 8, 1'b1);
        rows[6] = make_row(dlcm_init1, 20'h0, 8'h00, 20'h0, 1'b0, 12'h000, 6, 1'b1);
        rows[7] = make_row(dlcm_init2, 20'h0, 8'h00, 20'h0, 1'b0, 12'h000, 2, 1'b0);
        rows[8] = make_row(dlcm_active, 20'hFF800, 8'h80, 20'h01FFF, 1'b1, 12'hFFF, 4, 1'b0);
        repeat (10) @(posedge sclk);
        @(negedge sclk);
        rst_n_i = 1'b1;
        for (int i = 0; i < num_rows; i++) begin
            run_row(rows[i]);
        end
        $display("checks %0d, mismatches %0d, other failures %0d, assertion failures %0d",
                 checks, mismatches, failures, i_dut.i_properties.fail_count);
        if (mismatches + failures + i_dut.i_properties.fail_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// File: dllp_gen.f
logic/link_pkg.sv
logic/dllp_pkg.sv
logic/dllp_scheduler.sv
logic/dllp_assembler.sv
logic/dllp_crc_stage.sv
logic/dllp_framer.sv
logic/dllp_generator.sv
dv/dllp_generator_properties.sv
dv/dllp_generator_tb.sv
